/* verilog/bridge_pkg.sv */
package bridge_pkg;

  localparam int unsigned AddrWidth  = 16;
  localparam int unsigned DataWidth  = 32;

  // Crossing FIFO geometry
  localparam int unsigned LogDepth   = 3;
  localparam int unsigned Depth      = 2 ** LogDepth;
  localparam int unsigned SyncStages = 2;

  // Outstanding requests allowed past the isolation stage
  localparam int unsigned MaxPending = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Gray-coded, includes the wrap bit
  typedef logic [LogDepth:0] cdc_ptr_t;

  typedef logic [$clog2(MaxPending+1)-1:0] pending_cnt_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  write;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } bus_rsp_t;

  localparam int unsigned ReqWidth = $bits(bus_req_t);
  localparam int unsigned RspWidth = $bits(bus_rsp_t);

  typedef enum logic [1:0] {
    ISO_RUN,
    ISO_DRAIN,
    ISO_ISOLATED
  } iso_state_e;

endpackage

/* verilog/bus_isolate.sv */
`timescale 1ns/1ns

module bus_isolate (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 isolate_i,
  output logic                 isolated_o,
  input  bridge_pkg::bus_req_t slv_req_i,
  input  logic                 slv_req_valid_i,
  output logic                 slv_req_ready_o,
  output bridge_pkg::bus_rsp_t slv_rsp_o,
  output logic                 slv_rsp_valid_o,
  input  logic                 slv_rsp_ready_i,
  output bridge_pkg::bus_req_t mst_req_o,
  output logic                 mst_req_valid_o,
  input  logic                 mst_req_ready_i,
  input  bridge_pkg::bus_rsp_t mst_rsp_i,
  input  logic                 mst_rsp_valid_i,
  output logic                 mst_rsp_ready_o
);

  import bridge_pkg::*;

  iso_state_e   state_q;
  iso_state_e   state_d;
  pending_cnt_t cnt_q;
  logic         err_valid_q;
  logic         fwd_en;
  logic         req_fire;
  logic         rsp_fire;
  logic         err_take;
  logic         err_done;

  // Forward only while running and below the outstanding limit
  assign fwd_en = (state_q == ISO_RUN) && (cnt_q != pending_cnt_t'(MaxPending));

  assign mst_req_o       = slv_req_i;
  assign mst_req_valid_o = slv_req_valid_i && fwd_en;
  assign req_fire        = mst_req_valid_o && mst_req_ready_i;
  assign rsp_fire        = mst_rsp_valid_i && mst_rsp_ready_o;

  always_comb begin
    if (state_q == ISO_ISOLATED) begin
      // One locally terminated request at a time
      slv_req_ready_o = isolate_i && !err_valid_q;
    end else begin
      slv_req_ready_o = fwd_en && mst_req_ready_i;
    end
  end

  always_comb begin
    if (state_q == ISO_ISOLATED) begin
      slv_rsp_o.rdata = '0;
      slv_rsp_o.error = 1'b1;
      slv_rsp_valid_o = err_valid_q;
      mst_rsp_ready_o = 1'b0;
    end else begin
      slv_rsp_o       = mst_rsp_i;
      slv_rsp_valid_o = mst_rsp_valid_i;
      mst_rsp_ready_o = slv_rsp_ready_i;
    end
  end

  assign err_take = (state_q == ISO_ISOLATED) && slv_req_valid_i && slv_req_ready_o;
  assign err_done = (state_q == ISO_ISOLATED) && err_valid_q && slv_rsp_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ISO_RUN: begin
        if (isolate_i) begin
          state_d = ISO_DRAIN;
        end
      end
      ISO_DRAIN: begin
        if (!isolate_i) begin
          state_d = ISO_RUN;
        end else if (cnt_q == '0) begin
          state_d = ISO_ISOLATED;
        end
      end
      ISO_ISOLATED: begin
        if (!isolate_i && !err_valid_q) begin
          state_d = ISO_RUN;
        end
      end
      default: state_d = ISO_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ISO_RUN;
      cnt_q       <= '0;
      err_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (req_fire && !rsp_fire) begin
        cnt_q <= cnt_q + pending_cnt_t'(1);
      end else if (rsp_fire && !req_fire) begin
        cnt_q <= cnt_q - pending_cnt_t'(1);
      end
      if (err_take) begin
        err_valid_q <= 1'b1;
      end else if (err_done) begin
        err_valid_q <= 1'b0;
      end
    end
  end

  assign isolated_o = (state_q == ISO_ISOLATED);

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= pending_cnt_t'(MaxPending))
    else $error("outstanding count above limit");

  // Downstream only answers what was forwarded
  a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_rsp_valid_i |-> cnt_q != '0)
    else $error("response with nothing outstanding");

endmodule

/* verilog/cdc_fifo_src.sv */
`timescale 1ns/1ns

module cdc_fifo_src #(
  parameter int unsigned Width = 1
) (
  input  logic                                    src_clk_i,
  input  logic                                    rst_n_i,
  input  logic [Width-1:0]                        data_i,
  input  logic                                    valid_i,
  output logic                                    ready_o,
  output logic [bridge_pkg::Depth-1:0][Width-1:0] async_data_o,
  output bridge_pkg::cdc_ptr_t                    async_wptr_o,
  input  bridge_pkg::cdc_ptr_t                    async_rptr_i
);

  import bridge_pkg::*;

  logic [Depth-1:0][Width-1:0] mem_q;
  cdc_ptr_t                    wbin_q;
  cdc_ptr_t                    wgray_q;
  cdc_ptr_t                    wbin_next;
  cdc_ptr_t                    wgray_next;
  cdc_ptr_t [SyncStages-1:0]   rsync_q;
  cdc_ptr_t                    rptr_sync;
  logic                        ready_q;
  logic                        push;
  logic                        full_next;

  assign push       = valid_i && ready_q;
  assign wbin_next  = wbin_q + cdc_ptr_t'(push);
  assign wgray_next = wbin_next ^ (wbin_next >> 1);
  assign rptr_sync  = rsync_q[SyncStages-1];

  // Full when the top two gray bits differ and the rest match
  assign full_next = (wgray_next ==
                      {~rptr_sync[LogDepth:LogDepth-1], rptr_sync[LogDepth-2:0]});

  always_ff @(posedge src_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wbin_q  <= '0;
      wgray_q <= '0;
      rsync_q <= '0;
      ready_q <= 1'b0;
    end else begin
      wbin_q  <= wbin_next;
      wgray_q <= wgray_next;
      rsync_q <= {rsync_q[SyncStages-2:0], async_rptr_i};
      ready_q <= !full_next;
    end
  end

  always_ff @(posedge src_clk_i) begin
    if (push) begin
      mem_q[wbin_q[LogDepth-1:0]] <= data_i;
    end
  end

  assign ready_o      = ready_q;
  assign async_data_o = mem_q;
  assign async_wptr_o = wgray_q;

  // Ready comes from last cycle's view, so check against the current one
  a_no_write_full: assert property (@(posedge src_clk_i) disable iff (!rst_n_i)
    push |-> wgray_q != {~rptr_sync[LogDepth:LogDepth-1], rptr_sync[LogDepth-2:0]})
    else $error("write into a full FIFO");

endmodule

/* verilog/cdc_fifo_dst.sv */
`timescale 1ns/1ns

module cdc_fifo_dst #(
  parameter int unsigned Width = 1
) (
  input  logic                                    dst_clk_i,
  input  logic                                    rst_n_i,
  input  logic [bridge_pkg::Depth-1:0][Width-1:0] async_data_i,
  input  bridge_pkg::cdc_ptr_t                    async_wptr_i,
  output bridge_pkg::cdc_ptr_t                    async_rptr_o,
  output logic [Width-1:0]                        data_o,
  output logic                                    valid_o,
  input  logic                                    ready_i
);

  import bridge_pkg::*;

  cdc_ptr_t                  rbin_q;
  cdc_ptr_t                  rgray_q;
  cdc_ptr_t                  rbin_next;
  cdc_ptr_t                  rgray_next;
  cdc_ptr_t [SyncStages-1:0] wsync_q;
  cdc_ptr_t                  wptr_sync;
  logic                      empty;
  logic                      pop;

  assign wptr_sync = wsync_q[SyncStages-1];

  // Entries become visible only after the write pointer is synchronized
  assign empty   = (rgray_q == wptr_sync);
  assign valid_o = !empty;
  assign data_o  = async_data_i[rbin_q[LogDepth-1:0]];
  assign pop     = valid_o && ready_i;

  assign rbin_next  = rbin_q + cdc_ptr_t'(pop);
  assign rgray_next = rbin_next ^ (rbin_next >> 1);

  always_ff @(posedge dst_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rbin_q  <= '0;
      rgray_q <= '0;
      wsync_q <= '0;
    end else begin
      rbin_q  <= rbin_next;
      rgray_q <= rgray_next;
      wsync_q <= {wsync_q[SyncStages-2:0], async_wptr_i};
    end
  end

  assign async_rptr_o = rgray_q;

  a_no_read_empty: assert property (@(posedge dst_clk_i) disable iff (!rst_n_i)
    (rgray_q != $past(rgray_q)) |-> $past(valid_o))
    else $error("read pointer moved while empty");

endmodule

/* verilog/ext_port_bridge.sv */
`timescale 1ns/1ns

module ext_port_bridge (
  input  logic                 clk_i,
  input  logic                 dev_clk_i,
  input  logic                 rst_n_i,
  // Host side
  input  bridge_pkg::bus_req_t host_req_i,
  input  logic                 host_req_valid_i,
  output logic                 host_req_ready_o,
  output bridge_pkg::bus_rsp_t host_rsp_o,
  output logic                 host_rsp_valid_o,
  input  logic                 host_rsp_ready_i,
  input  logic                 isolate_i,
  output logic                 isolated_o,
  // Device side
  output bridge_pkg::bus_req_t dev_req_o,
  output logic                 dev_req_valid_o,
  input  logic                 dev_req_ready_i,
  input  bridge_pkg::bus_rsp_t dev_rsp_i,
  input  logic                 dev_rsp_valid_i,
  output logic                 dev_rsp_ready_o
);

  import bridge_pkg::*;

  bus_req_t iso_req;
  logic     iso_req_valid;
  logic     iso_req_ready;
  bus_rsp_t iso_rsp;
  logic     iso_rsp_valid;
  logic     iso_rsp_ready;

  logic [Depth-1:0][ReqWidth-1:0] req_async_data;
  cdc_ptr_t                       req_wptr;
  cdc_ptr_t                       req_rptr;
  logic [Depth-1:0][RspWidth-1:0] rsp_async_data;
  cdc_ptr_t                       rsp_wptr;
  cdc_ptr_t                       rsp_rptr;

  bus_isolate i_bus_isolate (
    .clk_i           ( clk_i            ),
    .rst_n_i         ( rst_n_i          ),
    .isolate_i       ( isolate_i        ),
    .isolated_o      ( isolated_o       ),
    .slv_req_i       ( host_req_i       ),
    .slv_req_valid_i ( host_req_valid_i ),
    .slv_req_ready_o ( host_req_ready_o ),
    .slv_rsp_o       ( host_rsp_o       ),
    .slv_rsp_valid_o ( host_rsp_valid_o ),
    .slv_rsp_ready_i ( host_rsp_ready_i ),
    .mst_req_o       ( iso_req          ),
    .mst_req_valid_o ( iso_req_valid    ),
    .mst_req_ready_i ( iso_req_ready    ),
    .mst_rsp_i       ( iso_rsp          ),
    .mst_rsp_valid_i ( iso_rsp_valid    ),
    .mst_rsp_ready_o ( iso_rsp_ready    )
  );

  // Requests, host clock to device clock
  cdc_fifo_src #(
    .Width ( ReqWidth )
  ) i_req_src (
    .src_clk_i    ( clk_i          ),
    .rst_n_i      ( rst_n_i        ),
    .data_i       ( iso_req        ),
    .valid_i      ( iso_req_valid  ),
    .ready_o      ( iso_req_ready  ),
    .async_data_o ( req_async_data ),
    .async_wptr_o ( req_wptr       ),
    .async_rptr_i ( req_rptr       )
  );

  cdc_fifo_dst #(
    .Width ( ReqWidth )
  ) i_req_dst (
    .dst_clk_i    ( dev_clk_i       ),
    .rst_n_i      ( rst_n_i         ),
    .async_data_i ( req_async_data  ),
    .async_wptr_i ( req_wptr        ),
    .async_rptr_o ( req_rptr        ),
    .data_o       ( dev_req_o       ),
    .valid_o      ( dev_req_valid_o ),
    .ready_i      ( dev_req_ready_i )
  );

  // Responses, device clock back to host clock
  cdc_fifo_src #(
    .Width ( RspWidth )
  ) i_rsp_src (
    .src_clk_i    ( dev_clk_i       ),
    .rst_n_i      ( rst_n_i         ),
    .data_i       ( dev_rsp_i       ),
    .valid_i      ( dev_rsp_valid_i ),
    .ready_o      ( dev_rsp_ready_o ),
    .async_data_o ( rsp_async_data  ),
    .async_wptr_o ( rsp_wptr        ),
    .async_rptr_i ( rsp_rptr        )
  );

  cdc_fifo_dst #(
    .Width ( RspWidth )
  ) i_rsp_dst (
    .dst_clk_i    ( clk_i          ),
    .rst_n_i      ( rst_n_i        ),
    .async_data_i ( rsp_async_data ),
    .async_wptr_i ( rsp_wptr       ),
    .async_rptr_o ( rsp_rptr       ),
    .data_o       ( iso_rsp        ),
    .valid_o      ( iso_rsp_valid  ),
    .ready_i      ( iso_rsp_ready  )
  );

endmodule

/* bench/device_model.sv */
`timescale 1ns/1ns

module device_model (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  bridge_pkg::bus_req_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output bridge_pkg::bus_rsp_t rsp_o,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output int unsigned          req_count_o
);

  import bridge_pkg::*;

  data_t       mem [16];
  logic [31:0] lcg_state;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
    req_count_o = 0;
    lcg_state   = 32'd16134;
    for (int i = 0; i < 16; i++) begin
      mem[i] = '0;
    end
  end

  // Sample on the edge, update outputs shortly after
  always @(posedge clk_i) begin : dev_step
    logic     rsp_done;
    logic     req_take;
    bus_req_t req;
    rsp_done = rsp_valid_o && rsp_ready_i;
    req_take = req_valid_i && req_ready_o;
    req      = req_i;
    #1;
    if (!rst_n_i) begin
      req_ready_o = 1'b0;
      rsp_valid_o = 1'b0;
    end else begin
      if (rsp_done) begin
        rsp_valid_o = 1'b0;
      end
      if (req_take) begin
        req_count_o++;
        rsp_o.error = 1'b0;
        if (req.write) begin
          mem[req.addr[3:0]] = req.wdata;
          rsp_o.rdata = '0;
        end else begin
          rsp_o.rdata = mem[req.addr[3:0]];
        end
        rsp_valid_o = 1'b1;
      end
      lcg_state = lcg_next(lcg_state);
      // One slot only, and about one cycle in four stalled
      req_ready_o = !rsp_valid_o && (lcg_state[23:22] != 2'b00);
    end
  end

endmodule

/* bench/bridge_tb.sv */
`timescale 1ns/1ns

module bridge_tb;

  import bridge_pkg::*;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_SYNC
  } op_e;

  typedef struct packed {
    op_e        op;
    addr_t      addr;
    data_t      wdata;
    logic       iso;
    logic [3:0] stall;
  } step_t;

  typedef struct packed {
    bus_rsp_t rsp;
    logic     fwd;
  } expect_t;

  localparam int NumSteps  = 26;
  localparam int ClkPeriod = 8;

  logic        clk_i;
  logic        dev_clk_i;
  logic        rst_n_i;
  bus_req_t    host_req_i;
  logic        host_req_valid_i;
  logic        host_req_ready_o;
  bus_rsp_t    host_rsp_o;
  logic        host_rsp_valid_o;
  logic        host_rsp_ready_i;
  logic        isolate_i;
  logic        isolated_o;
  bus_req_t    dev_req_o;
  logic        dev_req_valid_o;
  logic        dev_req_ready_i;
  bus_rsp_t    dev_rsp_i;
  logic        dev_rsp_valid_i;
  logic        dev_rsp_ready_o;
  int unsigned dev_req_count;

  step_t       steps [NumSteps];
  int          step_cnt;
  expect_t     exp_q [$];
  bus_req_t    req_q [$];
  data_t       ref_mem [16];
  logic [31:0] lcg_state;
  int          fwd_pending;
  int unsigned fwd_issued;
  int          error_count;

  always #(ClkPeriod / 2) clk_i = ~clk_i;
  always #6 dev_clk_i = ~dev_clk_i;

  ext_port_bridge i_dut (.*);

  device_model i_dev (
    .clk_i       ( dev_clk_i       ),
    .rst_n_i     ( rst_n_i         ),
    .req_i       ( dev_req_o       ),
    .req_valid_i ( dev_req_valid_o ),
    .req_ready_o ( dev_req_ready_i ),
    .rsp_o       ( dev_rsp_i       ),
    .rsp_valid_o ( dev_rsp_valid_i ),
    .rsp_ready_i ( dev_rsp_ready_o ),
    .req_count_o ( dev_req_count   )
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_count++;
      abort_run($sformatf("MISMATCH at %0t ns: %s: got %0h, expected %0h",
                          $time, what, actual, expected));
    end
  endtask

  task automatic add_step(input op_e op, input addr_t addr, input logic iso,
                          input logic stall_on);
    step_t       s;
    logic [31:0] rnd;
    rnd     = next_random();
    s.op    = op;
    s.addr  = addr;
    s.wdata = next_random();
    s.iso   = iso;
    s.stall = stall_on ? {1'b0, rnd[29:27]} + 4'd2 : 4'd0;
    steps[step_cnt] = s;
    step_cnt++;
  endtask

  task automatic build_table();
    // Writes then reads of the same words
    add_step(OP_WR,   16'h0003, 1'b0, 1'b0);
    add_step(OP_WR,   16'h0104, 1'b0, 1'b0);
    add_step(OP_WR,   16'h00a7, 1'b0, 1'b0);
    add_step(OP_SYNC, 16'h0000, 1'b0, 1'b0);
    add_step(OP_RD,   16'h0003, 1'b0, 1'b0);
    add_step(OP_RD,   16'h0104, 1'b0, 1'b0);
    add_step(OP_RD,   16'h00a7, 1'b0, 1'b0);
    add_step(OP_SYNC, 16'h0000, 1'b0, 1'b0);
    // Response back-pressure
    add_step(OP_WR,   16'h0005, 1'b0, 1'b1);
    add_step(OP_WR,   16'h0006, 1'b0, 1'b1);
    add_step(OP_RD,   16'h0013, 1'b0, 1'b1);
    add_step(OP_RD,   16'h0005, 1'b0, 1'b0);
    add_step(OP_WR,   16'h0003, 1'b0, 1'b1);
    add_step(OP_RD,   16'h0006, 1'b0, 1'b0);
    add_step(OP_RD,   16'h0003, 1'b0, 1'b1);
    add_step(OP_SYNC, 16'h0000, 1'b0, 1'b0);
    // Isolation raised while these are in flight
    add_step(OP_WR,   16'h0008, 1'b0, 1'b0);
    add_step(OP_WR,   16'h0009, 1'b0, 1'b0);
    add_step(OP_RD,   16'h0008, 1'b0, 1'b0);
    add_step(OP_RD,   16'h0008, 1'b1, 1'b0);
    add_step(OP_WR,   16'h0009, 1'b1, 1'b0);
    add_step(OP_RD,   16'h0005, 1'b1, 1'b1);
    add_step(OP_SYNC, 16'h0000, 1'b1, 1'b0);
    add_step(OP_RD,   16'h0009, 1'b0, 1'b0);
    add_step(OP_RD,   16'h0005, 1'b0, 1'b1);
    add_step(OP_SYNC, 16'h0000, 1'b0, 1'b0);
  endtask

  task automatic apply_isolate(input logic iso);
    if (isolate_i !== iso) begin
      isolate_i = iso;
      @(posedge clk_i);
      #1;
      if (!iso && exp_q.size() == 0) begin
        check_equal(isolated_o, 1'b0, "isolated_o after isolate_i falls");
      end
    end
  endtask

  task automatic hold_rsp_ready(input logic [3:0] cycles);
    host_rsp_ready_i = 1'b0;
    repeat (cycles) @(posedge clk_i);
    #1;
    host_rsp_ready_i = 1'b1;
  endtask

  task automatic send_request(input step_t step);
    bus_req_t req;
    expect_t  expected;
    logic     accepted;
    req.addr  = step.addr;
    req.write = (step.op == OP_WR);
    req.wdata = req.write ? step.wdata : '0;
    // Requests seen while isolating end locally with an error
    expected.fwd       = !step.iso;
    expected.rsp.error = step.iso;
    expected.rsp.rdata = '0;
    if (!step.iso && req.write) begin
      ref_mem[step.addr[3:0]] = step.wdata;
    end else if (!step.iso) begin
      expected.rsp.rdata = ref_mem[step.addr[3:0]];
    end
    host_req_i       = req;
    host_req_valid_i = 1'b1;
    accepted         = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = host_req_ready_o;
    end
    exp_q.push_back(expected);
    if (expected.fwd) begin
      fwd_pending++;
      fwd_issued++;
      req_q.push_back(req);
    end
    #1;
    host_req_valid_i = 1'b0;
  endtask

  task automatic wait_idle(input logic iso);
    while (exp_q.size() != 0 || isolated_o !== iso) begin
      @(posedge clk_i);
      #1;
    end
    check_equal(dev_req_count, fwd_issued, "device request count");
  endtask

  always @(posedge clk_i) begin : rsp_monitor
    expect_t expected;
    if (rst_n_i && host_rsp_valid_o && host_rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        abort_run("A response arrived with no request outstanding");
      end else begin
        expected = exp_q.pop_front();
        if (expected.fwd) begin
          fwd_pending--;
        end
        check_equal(host_rsp_o.rdata, expected.rsp.rdata, "response rdata");
        check_equal(host_rsp_o.error, expected.rsp.error, "response error");
      end
    end
    if (rst_n_i && isolated_o && fwd_pending != 0) begin
      abort_run("isolated_o was high while forwarded responses were still outstanding");
    end
  end

  // Forwarded requests reach the device unchanged and in order
  always @(posedge dev_clk_i) begin : req_monitor
    bus_req_t expected;
    if (rst_n_i && dev_req_valid_o && dev_req_ready_i) begin
      if (req_q.size() == 0) begin
        abort_run("A request reached the device that was never forwarded");
      end else begin
        expected = req_q.pop_front();
        check_equal(dev_req_o, expected, "device request");
      end
    end
  end

  initial begin
    #(NumSteps * 200 * ClkPeriod);
    abort_run("Watchdog expired: the tests did not finish in time");
  end

  initial begin
    clk_i            = 1'b0;
    dev_clk_i        = 1'b0;
    rst_n_i          = 1'b0;
    host_req_i       = '0;
    host_req_valid_i = 1'b0;
    host_rsp_ready_i = 1'b1;
    isolate_i        = 1'b0;
    lcg_state        = 32'd16134;
    step_cnt         = 0;
    fwd_pending      = 0;
    fwd_issued       = 0;
    error_count      = 0;
    for (int i = 0; i < 16; i++) begin
      ref_mem[i] = '0;
    end
    build_table();
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_equal(host_rsp_valid_o, 1'b0, "host_rsp_valid_o after reset");
    check_equal(isolated_o, 1'b0, "isolated_o after reset");
    check_equal(dev_req_valid_o, 1'b0, "dev_req_valid_o after reset");
    @(posedge clk_i);
    #1;
    check_equal(host_req_ready_o, 1'b1, "host_req_ready_o one cycle after reset");
    for (int i = 0; i < NumSteps; i++) begin
      apply_isolate(steps[i].iso);
      if (steps[i].op == OP_SYNC) begin
        wait_idle(steps[i].iso);
      end else begin
        if (steps[i].stall != 0) begin
          hold_rsp_ready(steps[i].stall);
        end
        send_request(steps[i]);
      end
    end
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
verilog/bridge_pkg.sv
verilog/bus_isolate.sv
verilog/cdc_fifo_src.sv
verilog/cdc_fifo_dst.sv
verilog/ext_port_bridge.sv
bench/device_model.sv
bench/bridge_tb.sv
